//--- hdl/msdap_cfg.svh
`ifndef MSDAP_CFG_SVH
`define MSDAP_CFG_SVH

// Number of coefficient groups (rj words per channel)
`define MSDAP_RJ_COUNT     4
// Coefficient words per channel, the rj values add up to this
`define MSDAP_COEFF_COUNT  16
// History depth, a power of two no larger than 256
`define MSDAP_HIST_DEPTH   8
// Zero run length before sleep, at least the history depth
`define MSDAP_SLEEP_ZEROS  8

`define MSDAP_WORD_W       16
`define MSDAP_ACC_W        40
`define MSDAP_FRAC_W       16

// Derived address widths
`define MSDAP_RJ_AW        $clog2(`MSDAP_RJ_COUNT)
`define MSDAP_COEFF_AW     $clog2(`MSDAP_COEFF_COUNT)
`define MSDAP_HIST_AW      $clog2(`MSDAP_HIST_DEPTH)

`endif

//--- hdl/msdapPkg.sv
`include "msdap_cfg.svh"

package msdapPkg;

    // Audio sample as it arrives on the word input
    typedef logic signed [`MSDAP_WORD_W-1:0] sample_t;

    // Accumulator and output word
    typedef logic signed [`MSDAP_ACC_W-1:0] acc_t;

    // Field layout of a coefficient word
    typedef struct packed {
        logic       negate;
        logic [6:0] unused;
        logic [7:0] histIdx;
    } coeffFields_t;

    // A loaded word is stored raw and decoded through its fields
    typedef union packed {
        logic [`MSDAP_WORD_W-1:0] raw;
        coeffFields_t             fields;
    } coeffWord_t;

    typedef enum logic [1:0] {
        idle,
        loadRj,
        loadCoeff,
        run
    } phase_t;

endpackage

//--- hdl/msdapIfs.sv
`timescale 1ns/1ns
`include "msdap_cfg.svh"

//////////////////////////////////////////////////
// Configuration write path, sequencer to stores
//////////////////////////////////////////////////
interface coeffLoadIf;

    logic                       wrEn;
    logic                       isRj;
    logic [`MSDAP_COEFF_AW-1:0] addr;
    logic [`MSDAP_WORD_W-1:0]   dataL;
    logic [`MSDAP_WORD_W-1:0]   dataR;

    modport source (
        output wrEn,
        output isRj,
        output addr,
        output dataL,
        output dataR
    );

    modport sink (
        input wrEn,
        input isRj,
        input addr,
        input dataL,
        input dataR
    );

endinterface

//////////////////////////////////////////////////
// Combinational read path, engine to its store
//////////////////////////////////////////////////
interface coeffReadIf import msdapPkg::*; ();

    logic [`MSDAP_RJ_AW-1:0]    rjAddr;
    logic [`MSDAP_WORD_W-1:0]   rjData;
    logic [`MSDAP_COEFF_AW-1:0] coeffAddr;
    coeffWord_t                 coeffWord;

    modport reader (output rjAddr, input rjData, output coeffAddr, input coeffWord);
    modport store (input rjAddr, output rjData, input coeffAddr, output coeffWord);

endinterface

//--- hdl/loadSequencer.sv
`timescale 1ns/1ns
`include "msdap_cfg.svh"

module loadSequencer
    import msdapPkg::*;
(
    input  logic       sClk,
    input  logic       done_L,
    input  logic       start,
    input  logic       frame,
    input  sample_t    inputL,
    input  sample_t    inputR,
    input  logic       busyL,
    input  logic       busyR,
    input  logic       doneL,
    input  logic       doneR,
    coeffLoadIf.source load,
    output logic       clearHist,
    output logic       sampleStrobe,
    output sample_t    sampleL,
    output sample_t    sampleR,
    output logic       computeGo,
    output logic       inReady,
    output logic       outReady,
    output logic       sleeping
);

    localparam int CNT_W = `MSDAP_COEFF_AW;
    // Run counter saturates one past the sleep threshold
    localparam int ZR_W  = $clog2(`MSDAP_SLEEP_ZEROS + 2);

    phase_t            phase;
    logic [CNT_W-1:0]  wordCnt;
    logic [ZR_W-1:0]   zeroRun;
    logic              calcPending;
    logic              accept;
    logic              isZero;
    logic              goSleep;
    logic              lastWord;

    //////////////////////////////////////////////////
    // Handshake and decode
    //////////////////////////////////////////////////
    assign accept   = frame && inReady;
    assign isZero   = (inputL == '0) && (inputR == '0);
    // This zero sample would push the run past the threshold
    assign goSleep  = isZero && (zeroRun >= ZR_W'(`MSDAP_SLEEP_ZEROS));
    assign lastWord = ((phase == loadRj) && (wordCnt == CNT_W'(`MSDAP_RJ_COUNT - 1)))
                   || ((phase == loadCoeff) && (wordCnt == CNT_W'(`MSDAP_COEFF_COUNT - 1)));

    // Configuration words go straight to both stores on the accepting edge
    assign load.wrEn  = accept && ((phase == loadRj) || (phase == loadCoeff));
    assign load.isRj  = (phase == loadRj);
    assign load.addr  = wordCnt;
    assign load.dataL = inputL;
    assign load.dataR = inputR;

    assign clearHist    = start;
    assign sampleStrobe = accept && (phase == run);
    assign sampleL      = inputL;
    assign sampleR      = inputR;

    //////////////////////////////////////////////////
    // Phase FSM
    //////////////////////////////////////////////////
    always_ff @(posedge sClk or posedge done_L)
    begin
        if (done_L)
        begin
            phase       <= idle;
            wordCnt     <= '0;
            zeroRun     <= '0;
            inReady     <= 1'b0;
            outReady    <= 1'b0;
            sleeping    <= 1'b0;
            computeGo   <= 1'b0;
            calcPending <= 1'b0;
        end
        else
        begin
            computeGo <= 1'b0;
            outReady  <= 1'b0;
            if (start)
            begin
                // Restart from any phase, an open computation is dropped
                phase       <= loadRj;
                wordCnt     <= '0;
                zeroRun     <= '0;
                inReady     <= 1'b1;
                sleeping    <= 1'b0;
                calcPending <= 1'b0;
            end
            else
            begin
                case (phase)
                    loadRj, loadCoeff:
                    begin
                        if (accept)
                        begin
                            if (lastWord)
                            begin
                                wordCnt <= '0;
                                phase   <= (phase == loadRj) ? loadCoeff : run;
                            end
                            else
                            begin
                                wordCnt <= wordCnt + 1'b1;
                            end
                        end
                    end
                    run:
                    begin
                        if (accept)
                        begin
                            if (!isZero)
                            begin
                                zeroRun <= '0;
                            end
                            else if (zeroRun <= ZR_W'(`MSDAP_SLEEP_ZEROS))
                            begin
                                zeroRun <= zeroRun + 1'b1;
                            end
                            sleeping <= goSleep;
                            // Sleeping samples are stored but not computed
                            if (!goSleep)
                            begin
                                inReady     <= 1'b0;
                                computeGo   <= 1'b1;
                                calcPending <= 1'b1;
                            end
                        end
                        // Both channels run in lockstep
                        if (calcPending && doneL && doneR)
                        begin
                            outReady    <= 1'b1;
                            calcPending <= 1'b0;
                        end
                        if (outReady && !busyL && !busyR)
                        begin
                            inReady <= 1'b1;
                        end
                    end
                    default:
                    begin
                        inReady <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/coeffStore.sv
`timescale 1ns/1ns
`include "msdap_cfg.svh"

module coeffStore
    import msdapPkg::*;
#(
    parameter bit isLeft = 1'b1
)
(
    input  logic      sClk,
    coeffLoadIf.sink  load,
    coeffReadIf.store rd
);

    localparam int RJ_AW = `MSDAP_RJ_AW;

    logic [`MSDAP_WORD_W-1:0] wrWord;
    logic [`MSDAP_WORD_W-1:0] rjMem [`MSDAP_RJ_COUNT];
    coeffWord_t               coeffMem [`MSDAP_COEFF_COUNT];

    // The only place where left and right differ
    assign wrWord = isLeft ? load.dataL : load.dataR;

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge sClk)
    begin
        if (load.wrEn && load.isRj)
        begin
            rjMem[load.addr[RJ_AW-1:0]] <= wrWord;
        end
        if (load.wrEn && !load.isRj)
        begin
            coeffMem[load.addr].raw <= wrWord;
        end
    end

    //////////////////////////////////////////////////
    // Read port, answered within the cycle
    //////////////////////////////////////////////////
    assign rd.rjData    = rjMem[rd.rjAddr];
    assign rd.coeffWord = coeffMem[rd.coeffAddr];

endmodule

//--- hdl/filterChannel.sv
`timescale 1ns/1ns
`include "msdap_cfg.svh"

module filterChannel
    import msdapPkg::*;
(
    input  logic       sClk,
    input  logic       done_L,
    input  logic       clearHist,
    input  logic       sampleStrobe,
    input  sample_t    sample,
    input  logic       computeGo,
    coeffReadIf.reader rd,
    output logic       busy,
    output logic       done,
    output acc_t       result
);

    localparam int HIST_AW  = `MSDAP_HIST_AW;
    localparam int RJ_AW    = `MSDAP_RJ_AW;
    localparam int COEFF_AW = `MSDAP_COEFF_AW;

    sample_t                  hist [`MSDAP_HIST_DEPTH];
    logic [HIST_AW-1:0]       wrPtr;
    logic [HIST_AW-1:0]       rdIdx;
    logic [RJ_AW-1:0]         grpIdx;
    logic [COEFF_AW-1:0]      coeffIdx;
    logic [`MSDAP_WORD_W-1:0] grpTaken;
    logic                     grpEnd;
    logic                     lastGrp;
    coeffWord_t               cw;
    acc_t                     tap;
    acc_t                     grpSum;
    acc_t                     acc;
    acc_t                     foldAcc;

    //////////////////////////////////////////////////
    // Circular history
    //////////////////////////////////////////////////
    always_ff @(posedge sClk or posedge done_L)
    begin
        if (done_L)
        begin
            wrPtr <= '0;
            for (int i = 0; i < `MSDAP_HIST_DEPTH; i++)
            begin
                hist[i] <= '0;
            end
        end
        else if (clearHist)
        begin
            wrPtr <= '0;
            for (int i = 0; i < `MSDAP_HIST_DEPTH; i++)
            begin
                hist[i] <= '0;
            end
        end
        else if (sampleStrobe)
        begin
            hist[wrPtr] <= sample;
            wrPtr       <= wrPtr + 1'b1;
        end
    end

    // Newest sample sits just below the write pointer, so index k is x[n-k]
    assign cw    = rd.coeffWord;
    assign rdIdx = wrPtr - HIST_AW'(1) - cw.fields.histIdx[HIST_AW-1:0];
    assign tap   = acc_t'(hist[rdIdx]) <<< `MSDAP_FRAC_W;

    assign rd.rjAddr    = grpIdx;
    assign rd.coeffAddr = coeffIdx;

    assign grpEnd  = (grpTaken == rd.rjData);
    assign lastGrp = (grpIdx == RJ_AW'(`MSDAP_RJ_COUNT - 1));
    // Weight of earlier groups doubles with each new group
    assign foldAcc = (acc <<< 1) + grpSum;

    //////////////////////////////////////////////////
    // Group walk, one coefficient or one fold per cycle
    //////////////////////////////////////////////////
    always_ff @(posedge sClk or posedge done_L)
    begin
        if (done_L)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            grpIdx   <= '0;
            coeffIdx <= '0;
            grpTaken <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (clearHist)
            begin
                busy <= 1'b0;
            end
            else if (computeGo)
            begin
                busy     <= 1'b1;
                grpIdx   <= '0;
                coeffIdx <= '0;
                grpTaken <= '0;
            end
            else if (busy)
            begin
                if (grpEnd)
                begin
                    grpTaken <= '0;
                    if (lastGrp)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                    else
                    begin
                        grpIdx <= grpIdx + 1'b1;
                    end
                end
                else
                begin
                    grpTaken <= grpTaken + 1'b1;
                    coeffIdx <= coeffIdx + 1'b1;
                end
            end
        end
    end

    // Datapath follows the walk above
    always_ff @(posedge sClk)
    begin
        if (computeGo)
        begin
            grpSum <= '0;
            acc    <= '0;
        end
        else if (busy)
        begin
            if (grpEnd)
            begin
                acc    <= foldAcc;
                grpSum <= '0;
                if (lastGrp)
                begin
                    result <= foldAcc >>> `MSDAP_RJ_COUNT;
                end
            end
            else
            begin
                grpSum <= cw.fields.negate ? grpSum - tap : grpSum + tap;
            end
        end
    end

endmodule

//--- hdl/msdapTop.sv
`timescale 1ns/1ns

module msdapTop
    import msdapPkg::*;
(
    input  logic    sClk,
    input  logic    done_L,
    input  logic    start,
    input  logic    frame,
    input  sample_t inputL,
    input  sample_t inputR,
    output logic    inReady,
    output logic    outReady,
    output acc_t    outputL,
    output acc_t    outputR,
    output logic    sleeping
);

    logic    clearHist;
    logic    sampleStrobe;
    sample_t sampleL;
    sample_t sampleR;
    logic    computeGo;
    logic    busyL;
    logic    busyR;
    logic    doneL;
    logic    doneR;

    coeffLoadIf loadBus ();
    coeffReadIf rdL ();
    coeffReadIf rdR ();

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////
    loadSequencer seq (
        .sClk         (sClk),
        .done_L       (done_L),
        .start        (start),
        .frame        (frame),
        .inputL       (inputL),
        .inputR       (inputR),
        .busyL        (busyL),
        .busyR        (busyR),
        .doneL        (doneL),
        .doneR        (doneR),
        .load         (loadBus.source),
        .clearHist    (clearHist),
        .sampleStrobe (sampleStrobe),
        .sampleL      (sampleL),
        .sampleR      (sampleR),
        .computeGo    (computeGo),
        .inReady      (inReady),
        .outReady     (outReady),
        .sleeping     (sleeping)
    );

    //////////////////////////////////////////////////
    // Left and right channels
    //////////////////////////////////////////////////
    coeffStore #(.isLeft(1'b1)) storeL (.sClk(sClk), .load(loadBus.sink), .rd(rdL.store));
    coeffStore #(.isLeft(1'b0)) storeR (.sClk(sClk), .load(loadBus.sink), .rd(rdR.store));

    filterChannel chanL (
        .sClk         (sClk),
        .done_L       (done_L),
        .clearHist    (clearHist),
        .sampleStrobe (sampleStrobe),
        .sample       (sampleL),
        .computeGo    (computeGo),
        .rd           (rdL.reader),
        .busy         (busyL),
        .done         (doneL),
        .result       (outputL)
    );

    filterChannel chanR (
        .sClk         (sClk),
        .done_L       (done_L),
        .clearHist    (clearHist),
        .sampleStrobe (sampleStrobe),
        .sample       (sampleR),
        .computeGo    (computeGo),
        .rd           (rdR.reader),
        .busy         (busyR),
        .done         (doneR),
        .result       (outputR)
    );

endmodule

//--- verif/msdap_asserts.sv
`timescale 1ns/1ns

module msdapAsserts
    import msdapPkg::*;
(
    input logic   sClk,
    input logic   done_L,
    input logic   inReady,
    input logic   outReady,
    input logic   sleeping,
    input phase_t phase
);

    // Failure count, read by the testbench summary
    int assertErrs = 0;

    //////////////////////////////////////////////////
    // Output handshake
    //////////////////////////////////////////////////
    // A result is presented for exactly one cycle
    outReadyPulse: assert property (@(posedge sClk) disable iff (done_L)
        outReady |=> !outReady)
    else
    begin
        $error("outReady stayed high for more than one cycle");
        assertErrs++;
    end

    // Sleeping samples never produce a result
    noOutWhileAsleep: assert property (@(posedge sClk) disable iff (done_L)
        !(outReady && sleeping))
    else
    begin
        $error("outReady pulsed while sleeping was high");
        assertErrs++;
    end

    //////////////////////////////////////////////////
    // Input handshake
    //////////////////////////////////////////////////
    // No new sample is taken while a result is presented
    inReadyLowAtOut: assert property (@(posedge sClk) disable iff (done_L)
        outReady |-> !inReady)
    else
    begin
        $error("inReady was high in the outReady cycle");
        assertErrs++;
    end

    idleNotReady: assert property (@(posedge sClk) disable iff (done_L)
        (phase == idle) |-> !inReady)
    else
    begin
        $error("inReady was high in the idle phase");
        assertErrs++;
    end

endmodule

bind msdapTop msdapAsserts chk (
    .sClk     (sClk),
    .done_L   (done_L),
    .inReady  (inReady),
    .outReady (outReady),
    .sleeping (sleeping),
    .phase    (seq.phase)
);

//--- verif/msdapTb.sv
`timescale 1ns/1ns

module msdapTb
    import msdapPkg::*;
();

    logic    sClk;
    logic    done_L;
    logic    start;
    logic    frame;
    sample_t inputL;
    sample_t inputR;
    logic    inReady;
    logic    outReady;
    acc_t    outputL;
    acc_t    outputR;
    logic    sleeping;

    // Parsed stimulus, one entry per data line
    byte     tagQ [$];
    sample_t leftQ [$];
    sample_t rightQ [$];
    acc_t    expLQ [$];
    acc_t    expRQ [$];

    int mismatchCnt = 0;
    int failCnt     = 0;
    int cycleCnt    = 0;
    int cycleLimit  = 1000;

    msdapTop dut (
        .sClk     (sClk),
        .done_L   (done_L),
        .start    (start),
        .frame    (frame),
        .inputL   (inputL),
        .inputR   (inputR),
        .inReady  (inReady),
        .outReady (outReady),
        .outputL  (outputL),
        .outputR  (outputR),
        .sleeping (sleeping)
    );

    initial
    begin
        sClk = 1'b0;
        forever #2 sClk = ~sClk;
    end

    // Run limit, armed once the stimulus is parsed
    always @(posedge sClk)
    begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit)
        begin
            $display("TIMEOUT: stimulus not finished after %0d cycles, %0d mismatches so far",
                     cycleCnt, mismatchCnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic compareAcc(input string name, input acc_t expected, input acc_t actual);
        if (actual !== expected)
        begin
            mismatchCnt++;
            $display("MISMATCH %s: expected %0d (0x%h), actual %0d (0x%h)",
                     name, expected, expected, actual, actual);
        end
    endtask

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            mismatchCnt++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////
    task automatic loadVectors();
        int             fd;
        int             n;
        byte            tagCh;
        logic [2047:0]  skipBuf;
        sample_t        l;
        sample_t        r;
        acc_t           eL;
        acc_t           eR;
        bit             bad;
        fd  = $fopen("verif/msdap_input.txt", "r");
        bad = 1'b0;
        if (fd == 0)
        begin
            $display("ERROR: could not open the stimulus file verif/msdap_input.txt");
            failCnt++;
        end
        else
        begin
            while (!$feof(fd) && !bad)
            begin
                eL = '0;
                eR = '0;
                n  = $fscanf(fd, " %c", tagCh);
                if (n == 1)
                begin
                    if (tagCh == "#")
                    begin
                        n = $fgets(skipBuf, fd);
                    end
                    else if (tagCh == "R" || tagCh == "C" || tagCh == "S" || tagCh == "Z")
                    begin
                        if (tagCh == "S")
                        begin
                            n = $fscanf(fd, "%h %h %h %h", l, r, eL, eR);
                            bad = (n != 4);
                        end
                        else
                        begin
                            n = $fscanf(fd, "%h %h", l, r);
                            bad = (n != 2);
                        end
                        tagQ.push_back(tagCh);
                        leftQ.push_back(l);
                        rightQ.push_back(r);
                        expLQ.push_back(eL);
                        expRQ.push_back(eR);
                    end
                    else
                    begin
                        bad = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (bad)
            begin
                $display("ERROR: stimulus file has a malformed entry after %0d vectors",
                         tagQ.size());
                failCnt++;
            end
        end
        if (tagQ.size() == 0)
        begin
            $display("ERROR: no stimulus vectors were read");
            failCnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // Bus actions
    //////////////////////////////////////////////////
    task automatic pulseStart();
        @(posedge sClk);
        #1;
        start = 1'b1;
        @(posedge sClk);
        #1;
        start = 1'b0;
    endtask

    // Holds frame for one accepting edge once inReady is seen
    task automatic sendWord(input sample_t l, input sample_t r);
        @(posedge sClk);
        #1;
        while (!inReady)
        begin
            @(posedge sClk);
            #1;
        end
        frame  = 1'b1;
        inputL = l;
        inputR = r;
        @(posedge sClk);
        #1;
        frame = 1'b0;
    endtask

    task automatic waitResult(input string name);
        compareBit({name, " inReady while computing"}, 1'b0, inReady);
        while (!outReady)
        begin
            @(posedge sClk);
            #1;
        end
    endtask

    // A sleeping sample gives no result and leaves inReady high
    task automatic waitStillReady(input string name);
        compareBit({name, " outReady"}, 1'b0, outReady);
        while (!inReady)
        begin
            @(posedge sClk);
            #1;
            compareBit({name, " outReady"}, 1'b0, outReady);
        end
    endtask

    // Frames before the first start are ignored
    task automatic checkIdle();
        for (int i = 0; i < 6; i++)
        begin
            @(posedge sClk);
            #1;
            frame  = 1'b1;
            inputL = 16'h1111;
            inputR = 16'h2222;
            compareBit("idle inReady", 1'b0, inReady);
            compareBit("idle outReady", 1'b0, outReady);
            compareBit("idle sleeping", 1'b0, sleeping);
        end
        frame = 1'b0;
    endtask

    task automatic runVector(input int idx);
        string name;
        name = $sformatf("vector %0d %c", idx + 1, tagQ[idx]);
        // A new block of rj words begins a new configuration
        if (tagQ[idx] == "R" && (idx == 0 || tagQ[idx - 1] != "R"))
        begin
            pulseStart();
        end
        sendWord(leftQ[idx], rightQ[idx]);
        if (tagQ[idx] == "S")
        begin
            waitResult(name);
            compareAcc({name, " outputL"}, expLQ[idx], outputL);
            compareAcc({name, " outputR"}, expRQ[idx], outputR);
            compareBit({name, " sleeping"}, 1'b0, sleeping);
        end
        else if (tagQ[idx] == "Z")
        begin
            waitStillReady(name);
            compareBit({name, " sleeping"}, 1'b1, sleeping);
        end
        else
        begin
            compareBit({name, " inReady during load"}, 1'b1, inReady);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial
    begin
        done_L = 1'b1;
        start  = 1'b0;
        frame  = 1'b0;
        inputL = '0;
        inputR = '0;
        loadVectors();
        cycleLimit = 40 * (tagQ.size() + 1);
        repeat (3) @(posedge sClk);
        #1;
        done_L = 1'b0;
        checkIdle();
        for (int i = 0; i < tagQ.size(); i++)
        begin
            runVector(i);
        end
        repeat (4) @(posedge sClk);
        $display("Summary: %0d mismatches, %0d assertion failures, %0d other errors, %0d vectors",
                 mismatchCnt, dut.chk.assertErrs, failCnt, tagQ.size());
        if (mismatchCnt == 0 && failCnt == 0 && dut.chk.assertErrs == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/msdapPkg.sv
hdl/msdapIfs.sv
hdl/loadSequencer.sv
hdl/coeffStore.sv
hdl/filterChannel.sv
hdl/msdapTop.sv
verif/msdap_asserts.sv
verif/msdapTb.sv

//--- verif/msdap_input.txt
# tag left right [expL expR], hex; outputs are 40-bit two's complement
# R rj word, C coeff word, S sample and result, Z sample taken asleep
# Config 1, group sizes 3 5 2 6
R 0003 0003
R 0005 0005
R 0002 0002
R 0006 0006
C 0000 8000
C 0001 0003
C 8002 0005
C 0000 0001
C 8003 0001
C 0004 8002
C 0005 0006
C 8001 0007
C 0006 8000
C 8007 8004
C 0000 0001
C 0002 0002
C 8003 0003
C 0005 8004
C 8006 8005
C 0007 0000
# Impulse walks through the taps
S 0001 0001 000000D000 FFFFFF7000
S 0000 0000 0000004000 0000009000
S 0000 0000 FFFFFF9000 FFFFFFD000
S 0000 0000 FFFFFFB000 0000009000
S 0000 0000 0000004000 FFFFFFD000
S 0000 0000 0000005000 0000007000
S 0000 0000 0000001000 0000004000
S 0000 0000 FFFFFFF000 0000004000
# Mixed signed pairs
S 0064 FFCE 0000514000 00001C2000
S FF38 012C FFFF768000 FFFF3B2000
S 7FFF 8000 0067A17000 0048B22000
S 0000 0007 0020380000 FFB7A7B000
# Zero run, the ninth zero pair sleeps
S 0000 0000 FFC857F000 0018B61000
S 0000 0000 FFD7ED9000 FFB7B09000
S 0000 0000 001FC78000 00187AB000
S 0000 0000 0027ECF000 FFC83D3000
S 0000 0000 00080C7000 FFE04E1000
S 0000 0000 FFF8001000 FFE001C000
S 0000 0000 0000000000 000001C000
S 0000 0000 0000000000 0000000000
Z 0000 0000
Z 0000 0000
S 0010 FFFD 00000D0000 000001B000
# Config 2 after a new start, group sizes 4 4 4 4
R 0004 0004
R 0004 0004
R 0004 0004
R 0004 0004
C 0000 8001
C 0000 8001
C 0000 0002
C 0001 0002
C 0001 0000
C 0001 0000
C 8002 0000
C 0003 0000
C 0000 0005
C 8000 0006
C 0000 0007
C 0004 8007
C 8001 0000
C 8001 0003
C 8001 0003
C 0007 8003
S 0003 0002 000004E000 0000022000
S FFFF 0100 000000D000 00010E0000
S 0002 FFFF 000001B000 FFFF00F000
